// File: bus/wb_addr_decode.sv
`timescale 1ns/1ns

module wb_addr_decode #(
   parameter int NUM_BANKS  = tile_cfg_pkg::DEF_NUM_BANKS,
   parameter int BANK_WORDS = tile_cfg_pkg::DEF_BANK_WORDS
) (
   input  wb_pkg::wb_adr_t adr_i,
   input  wb_pkg::wb_dat_t dat_i,
   input  wb_pkg::wb_sel_t sel_i,
   input  logic            we_i,
   input  logic            cyc_i,
   input  logic            stb_i,
   output logic            req_miss_o,
   output logic [tile_cfg_pkg::idx_width(NUM_BANKS)-1:0] req_bank_o,
   wb_if.master            bank_o [NUM_BANKS-1:0]
);

   localparam int BANK_IDX_W = tile_cfg_pkg::idx_width(NUM_BANKS);
   localparam int WORD_IDX_W = wb_pkg::ADR_W - tile_cfg_pkg::ADR_LSB;
   localparam int WIN_LSB    = wb_pkg::ADR_W - tile_cfg_pkg::MEM_RANGE_WIDTH;

   logic                  req;
   logic                  in_window;
   logic                  bank_valid;
   logic                  hit;
   logic [WORD_IDX_W-1:0] word_idx;
   logic [WORD_IDX_W-1:0] bank_full;
   logic [NUM_BANKS-1:0]  bank_hit;

   assign req       = cyc_i & stb_i;
   assign in_window = (adr_i[wb_pkg::ADR_W-1:WIN_LSB] == tile_cfg_pkg::MEM_RANGE_MATCH);
   assign word_idx  = adr_i[wb_pkg::ADR_W-1:tile_cfg_pkg::ADR_LSB]; // Address divided by four

   // Bank number before the range check
   assign bank_full  = word_idx / WORD_IDX_W'(BANK_WORDS);
   assign bank_valid = (bank_full < WORD_IDX_W'(NUM_BANKS));
   assign hit        = in_window & bank_valid;

   assign req_miss_o = req & ~hit;
   assign req_bank_o = bank_full[BANK_IDX_W-1:0];

   generate
      for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_fanout
         assign bank_hit[b] = hit && (bank_full == WORD_IDX_W'(b));

         // Payload goes to every bank, strobe only to the selected one
         assign bank_o[b].adr   = adr_i;
         assign bank_o[b].dat_w = dat_i;
         assign bank_o[b].sel   = sel_i;
         assign bank_o[b].we    = we_i;
         assign bank_o[b].cyc   = cyc_i & bank_hit[b];
         assign bank_o[b].stb   = stb_i & bank_hit[b];
      end
   endgenerate

endmodule

// File: bus/wb_resp_collect.sv
`timescale 1ns/1ns

module wb_resp_collect #(
   parameter int NUM_BANKS = tile_cfg_pkg::DEF_NUM_BANKS
) (
   input  logic            clk_i,
   input  logic            rst_n_i,
   input  logic            req_miss_i,
   input  logic [tile_cfg_pkg::idx_width(NUM_BANKS)-1:0] req_bank_i,
   wb_if.monitor           bank_i [NUM_BANKS-1:0],
   output logic            ack_o,
   output logic            err_o,
   output wb_pkg::wb_dat_t dat_o
);

   localparam int BANK_IDX_W = tile_cfg_pkg::idx_width(NUM_BANKS);

   logic [NUM_BANKS-1:0]  bank_ack;
   logic [NUM_BANKS-1:0]  bank_req;
   wb_pkg::wb_dat_t       bank_dat [NUM_BANKS];
   logic                  miss_q;
   logic                  err_q;
   logic [BANK_IDX_W-1:0] bank_q;

   // Flatten the bank buses for indexing
   generate
      for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_gather
         assign bank_ack[b] = bank_i[b].ack;
         assign bank_req[b] = bank_i[b].cyc & bank_i[b].stb;
         assign bank_dat[b] = bank_i[b].dat_r;
      end
   endgenerate

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         miss_q <= 1'b0;
         err_q  <= 1'b0;
         bank_q <= '0;
      end else begin
         miss_q <= req_miss_i;
         err_q  <= req_miss_i & ~miss_q; // One err per miss, even with stb held
         if (|bank_req) begin
            bank_q <= req_bank_i; // Bank that answers next cycle
         end
      end
   end

   assign ack_o = |bank_ack; // At most one bank strobed
   assign err_o = err_q;
   assign dat_o = bank_dat[bank_q];

endmodule

// File: common/tile_cfg_pkg.sv
package tile_cfg_pkg;

   // Local memory window, upper address bits of a request
   localparam int MEM_RANGE_WIDTH = 4;
   localparam logic [MEM_RANGE_WIDTH-1:0] MEM_RANGE_MATCH = '0; // Window starts at zero

   // Byte offset bits inside one bus word
   localparam int ADR_LSB = 2;

   // Defaults handed down by the top level
   localparam int DEF_NUM_BANKS  = 4;
   localparam int DEF_BANK_WORDS = 256; // Words per bank, power of two

   // Index width for n entries, at least one bit
   function automatic int idx_width(input int n);
      int w;
      w = 1;
      if (n > 1) begin
         w = $clog2(n);
      end
      return w;
   endfunction

endpackage

// File: common/wb_if.sv
`timescale 1ns/1ns

interface wb_if;

   // Request side
   wb_pkg::wb_adr_t adr;
   wb_pkg::wb_dat_t dat_w;
   wb_pkg::wb_sel_t sel;
   logic            we;
   logic            cyc;
   logic            stb;

   // Response side
   logic            ack;
   wb_pkg::wb_dat_t dat_r;

   modport master (
      output adr, dat_w, sel, we, cyc, stb,
      input  ack, dat_r
   );

   modport slave (
      input  adr, dat_w, sel, we, cyc, stb,
      output ack, dat_r
   );

   modport monitor (
      input adr, dat_w, sel, we, cyc, stb, ack, dat_r
   );

endinterface

// File: common/wb_pkg.sv
package wb_pkg;

   localparam int ADR_W = 32; // Byte address
   localparam int DAT_W = 32; // One bus word
   localparam int SEL_W = DAT_W / 8; // Byte lanes

   typedef logic [ADR_W-1:0] wb_adr_t;
   typedef logic [DAT_W-1:0] wb_dat_t;
   typedef logic [SEL_W-1:0] wb_sel_t;

endpackage

// File: rtl/tile_mem_top.sv
`timescale 1ns/1ns

module tile_mem_top #(
   parameter int NUM_BANKS  = tile_cfg_pkg::DEF_NUM_BANKS,
   parameter int BANK_WORDS = tile_cfg_pkg::DEF_BANK_WORDS
) (
   input  logic            clk,
   input  logic            rst_n_i,

   // Wishbone slave port towards the cores
   input  wb_pkg::wb_adr_t wb_adr_i,
   input  wb_pkg::wb_dat_t wb_dat_i,
   input  wb_pkg::wb_sel_t wb_sel_i,
   input  logic            wb_we_i,
   input  logic            wb_cyc_i,
   input  logic            wb_stb_i,
   output logic            wb_ack_o,
   output logic            wb_err_o,
   output wb_pkg::wb_dat_t wb_dat_o
);

   localparam int BANK_IDX_W = tile_cfg_pkg::idx_width(NUM_BANKS);

   logic                  req_miss;
   logic [BANK_IDX_W-1:0] req_bank;

   wb_if bank_bus [NUM_BANKS-1:0] (); // One bus per bank

   wb_addr_decode #(
      .NUM_BANKS  (NUM_BANKS),
      .BANK_WORDS (BANK_WORDS)
   ) u_decode (
      .adr_i      (wb_adr_i),
      .dat_i      (wb_dat_i),
      .sel_i      (wb_sel_i),
      .we_i       (wb_we_i),
      .cyc_i      (wb_cyc_i),
      .stb_i      (wb_stb_i),
      .req_miss_o (req_miss),
      .req_bank_o (req_bank),
      .bank_o     (bank_bus)
   );

   generate
      for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
         wb_sram_bank #(
            .BANK_WORDS (BANK_WORDS)
         ) u_bank (
            .clk_i   (clk),
            .rst_n_i (rst_n_i),
            .bus_s   (bank_bus[b])
         );
      end
   endgenerate

   wb_resp_collect #(
      .NUM_BANKS (NUM_BANKS)
   ) u_collect (
      .clk_i      (clk),
      .rst_n_i    (rst_n_i),
      .req_miss_i (req_miss),
      .req_bank_i (req_bank),
      .bank_i     (bank_bus),
      .ack_o      (wb_ack_o),
      .err_o      (wb_err_o),
      .dat_o      (wb_dat_o)
   );

endmodule

// File: rtl/wb_sram_bank.sv
`timescale 1ns/1ns

module wb_sram_bank #(
   parameter int BANK_WORDS = tile_cfg_pkg::DEF_BANK_WORDS
) (
   input logic  clk_i,
   input logic  rst_n_i,
   wb_if.slave  bus_s
);

   localparam int WORD_AW = tile_cfg_pkg::idx_width(BANK_WORDS);

   wb_pkg::wb_dat_t    mem [BANK_WORDS];
   wb_pkg::wb_dat_t    dat_q;
   logic [WORD_AW-1:0] word_idx;
   logic               req;
   logic               req_q;
   logic               req_start;
   logic               ack_q;

   // Word within the bank, remainder of the word index
   assign word_idx  = bus_s.adr[tile_cfg_pkg::ADR_LSB +: WORD_AW];
   assign req       = bus_s.cyc & bus_s.stb;
   assign req_start = req & ~req_q; // First cycle of a strobe

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         req_q <= 1'b0;
         ack_q <= 1'b0;
      end else begin
         req_q <= req;
         ack_q <= req_start; // Single cycle ack
      end
   end

   // Storage array and read register
   always_ff @(posedge clk_i) begin
      if (req_start && bus_s.we) begin
         for (int i = 0; i < wb_pkg::SEL_W; i++) begin
            if (bus_s.sel[i]) begin
               mem[word_idx][8*i +: 8] <= bus_s.dat_w[8*i +: 8]; // Byte lane write
            end
         end
      end
      if (req_start && !bus_s.we) begin
         dat_q <= mem[word_idx];
      end
   end

   assign bus_s.ack   = ack_q;
   assign bus_s.dat_r = dat_q;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -j 0 \
   --top-module tb_tile_mem -Mdir obj_dir -o tb_tile_mem_sim -f sim.f \
   || { echo "RESULT: build failed"; exit 1; }

./obj_dir/tb_tile_mem_sim > "$LOG" 2>&1
cat "$LOG"

grep -q "tests failed" "$LOG" && { echo "RESULT: FAIL"; exit 1; }
grep -q "all tests passed" "$LOG" || { echo "RESULT: FAIL, run ended early"; exit 1; }
echo "RESULT: PASS"

// File: sim.f
common/wb_pkg.sv
common/tile_cfg_pkg.sv
common/wb_if.sv
rtl/wb_sram_bank.sv
bus/wb_addr_decode.sv
bus/wb_resp_collect.sv
rtl/tile_mem_top.sv
tb/tile_mem_props.sv
tb/tb_tile_mem.sv

// File: tb/tb_tile_mem.sv
`timescale 1ns/1ns

module tb_tile_mem;

   localparam int NUM_BANKS    = tile_cfg_pkg::DEF_NUM_BANKS;
   localparam int BANK_WORDS   = tile_cfg_pkg::DEF_BANK_WORDS;
   localparam int TOTAL_WORDS  = NUM_BANKS * BANK_WORDS;
   localparam int RESET_CYCLES = 10;
   localparam int RAND_COUNT   = 60;

   typedef enum logic [1:0] {
      RESP_NONE,
      RESP_ACK,
      RESP_ERR,
      RESP_BOTH
   } resp_t;

   logic            clk;
   logic            rst_n_i;
   wb_pkg::wb_adr_t wb_adr_i;
   wb_pkg::wb_dat_t wb_dat_i;
   wb_pkg::wb_sel_t wb_sel_i;
   logic            wb_we_i;
   logic            wb_cyc_i;
   logic            wb_stb_i;
   logic            wb_ack_o;
   logic            wb_err_o;
   wb_pkg::wb_dat_t wb_dat_o;

   // Stimulus table with one entry per bus access
   string           tbl_name [$];
   wb_pkg::wb_adr_t tbl_adr  [$];
   logic            tbl_we   [$];
   wb_pkg::wb_dat_t tbl_dat  [$];
   wb_pkg::wb_sel_t tbl_sel  [$];
   resp_t           tbl_resp [$];
   wb_pkg::wb_dat_t tbl_exp  [$];
   bit              table_ready;

   wb_pkg::wb_dat_t ref_mem   [TOTAL_WORDS]; // Reference model over all banks
   bit              ref_valid [TOTAL_WORDS];
   int unsigned     written   [$];           // Words holding defined data

   tile_mem_top #(
      .NUM_BANKS  (NUM_BANKS),
      .BANK_WORDS (BANK_WORDS)
   ) uut (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .wb_adr_i (wb_adr_i),
      .wb_dat_i (wb_dat_i),
      .wb_sel_i (wb_sel_i),
      .wb_we_i  (wb_we_i),
      .wb_cyc_i (wb_cyc_i),
      .wb_stb_i (wb_stb_i),
      .wb_ack_o (wb_ack_o),
      .wb_err_o (wb_err_o),
      .wb_dat_o (wb_dat_o)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic wb_pkg::wb_adr_t word_to_addr(input int unsigned word);
      return word << tile_cfg_pkg::ADR_LSB;
   endfunction

   function automatic int unsigned addr_to_word(input wb_pkg::wb_adr_t adr);
      return adr >> tile_cfg_pkg::ADR_LSB;
   endfunction

   // Address with the window bits flipped and low bits zero
   function automatic wb_pkg::wb_adr_t outside_addr();
      wb_pkg::wb_adr_t adr;
      adr = '0;
      adr[wb_pkg::ADR_W-1 -: tile_cfg_pkg::MEM_RANGE_WIDTH] = ~tile_cfg_pkg::MEM_RANGE_MATCH;
      return adr;
   endfunction

   function automatic resp_t sample_resp();
      resp_t resp;
      case ({wb_ack_o, wb_err_o})
         2'b10:   resp = RESP_ACK;
         2'b01:   resp = RESP_ERR;
         2'b11:   resp = RESP_BOTH;
         default: resp = RESP_NONE;
      endcase
      return resp;
   endfunction

   task automatic check_resp(input string name, input resp_t exp, input resp_t act);
      if (exp !== act) begin
         $display("error %s: expected response %s, actual %s", name, exp.name(), act.name());
         $display("tests failed");
         $fatal(1, "response mismatch");
      end
   endtask

   task automatic check_dat(input string name, input wb_pkg::wb_dat_t exp,
                            input wb_pkg::wb_dat_t act);
      if (exp !== act) begin
         $display("error %s: expected data %h, actual %h", name, exp, act);
         $display("tests failed");
         $fatal(1, "data mismatch");
      end
   endtask

   task automatic add_entry(input string name, input wb_pkg::wb_adr_t adr, input logic we,
                            input wb_pkg::wb_dat_t dat, input wb_pkg::wb_sel_t sel,
                            input resp_t resp, input wb_pkg::wb_dat_t exp);
      tbl_name.push_back(name);
      tbl_adr.push_back(adr);
      tbl_we.push_back(we);
      tbl_dat.push_back(dat);
      tbl_sel.push_back(sel);
      tbl_resp.push_back(resp);
      tbl_exp.push_back(exp);
   endtask

   task automatic build_table();
      int unsigned     word;
      wb_pkg::wb_dat_t dat;
      int unsigned     part;
      for (int b = 0; b < NUM_BANKS; b++) begin
         word = b * BANK_WORDS + b * 17; // Bank 0 uses word 0
         dat  = 32'h1357_9BDF ^ wb_pkg::wb_dat_t'(b * 32'h0101_0101);
         add_entry($sformatf("bank%0d write", b), word_to_addr(word), 1'b1, dat, '1, RESP_ACK, '0);
         add_entry($sformatf("bank%0d read", b), word_to_addr(word), 1'b0, '0, '1, RESP_ACK, dat);
      end
      word = TOTAL_WORDS - 1; // Last word of the last bank
      add_entry("last word write", word_to_addr(word), 1'b1, 32'hF0E1_D2C3, '1, RESP_ACK, '0);
      add_entry("last word read", word_to_addr(word), 1'b0, '0, '1, RESP_ACK, 32'hF0E1_D2C3);

      part = BANK_WORDS + 9;
      add_entry("partial base", word_to_addr(part), 1'b1, 32'h1122_3344, '1, RESP_ACK, '0);
      add_entry("partial lanes 0 2", word_to_addr(part), 1'b1, 32'hAABB_CCDD, 4'b0101,
                RESP_ACK, '0);
      add_entry("partial read 1", word_to_addr(part), 1'b0, '0, '1, RESP_ACK, 32'h11BB_33DD);
      add_entry("partial lane 3", word_to_addr(part), 1'b1, 32'h5566_7788, 4'b1000,
                RESP_ACK, '0);
      add_entry("partial read 2", word_to_addr(part), 1'b0, '0, '1, RESP_ACK, 32'h55BB_33DD);

      // Miss addresses alias word 0 and the partial word in their low bits
      add_entry("beyond banks read", word_to_addr(TOTAL_WORDS), 1'b0, '0, '1, RESP_ERR, '0);
      add_entry("beyond banks write", word_to_addr(TOTAL_WORDS), 1'b1, 32'hDEAD_BEEF, '1,
                RESP_ERR, '0);
      add_entry("outside read", outside_addr(), 1'b0, '0, '1, RESP_ERR, '0);
      add_entry("outside write", outside_addr(), 1'b1, 32'h0BAD_F00D, '1, RESP_ERR, '0);
      add_entry("outside write alias", outside_addr() | word_to_addr(part), 1'b1,
                32'h0000_0000, '1, RESP_ERR, '0);
      add_entry("word 0 unchanged", word_to_addr(0), 1'b0, '0, '1, RESP_ACK, 32'h1357_9BDF);
      add_entry("partial unchanged", word_to_addr(part), 1'b0, '0, '1, RESP_ACK,
                32'h55BB_33DD);
   endtask

   task automatic model_write(input int unsigned word, input wb_pkg::wb_dat_t dat,
                              input wb_pkg::wb_sel_t sel);
      for (int i = 0; i < wb_pkg::SEL_W; i++) begin
         if (sel[i]) begin
            ref_mem[word][8*i +: 8] = dat[8*i +: 8];
         end
      end
      if (!ref_valid[word]) begin
         ref_valid[word] = 1'b1;
         written.push_back(word);
      end
   endtask

   // Called on a falling edge and returns on the falling edge after the idle cycle
   task automatic run_access(input wb_pkg::wb_adr_t adr, input logic we,
                             input wb_pkg::wb_dat_t dat, input wb_pkg::wb_sel_t sel,
                             output resp_t resp, output wb_pkg::wb_dat_t rdat);
      wb_adr_i = adr;
      wb_dat_i = dat;
      wb_sel_i = sel;
      wb_we_i  = we;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      @(negedge clk); // Response is due one cycle after the strobe
      resp     = sample_resp();
      rdat     = wb_dat_o;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      @(negedge clk);
   endtask

   task automatic run_random(input int count);
      resp_t           resp;
      wb_pkg::wb_dat_t rdat;
      wb_pkg::wb_dat_t dat;
      wb_pkg::wb_sel_t sel;
      int unsigned     word;
      logic            we;
      string           name;
      for (int n = 0; n < count; n++) begin
         we = (written.size() == 0) || ($urandom % 2 == 1);
         if (we) begin
            word = $urandom % TOTAL_WORDS;
            dat  = $urandom;
            sel  = ref_valid[word] ? wb_pkg::wb_sel_t'($urandom % 16) : '1; // Full word first
         end else begin
            word = written[$urandom % written.size()];
            dat  = '0;
            sel  = '1;
         end
         name = $sformatf("random %0d", n);
         run_access(word_to_addr(word), we, dat, sel, resp, rdat);
         check_resp(name, RESP_ACK, resp);
         if (we) begin
            model_write(word, dat, sel);
         end else begin
            check_dat(name, ref_mem[word], rdat);
         end
      end
   endtask

   initial begin : watchdog
      int limit;
      wait (table_ready);
      limit = (tbl_name.size() + RAND_COUNT) * 4 + RESET_CYCLES;
      repeat (limit) @(posedge clk);
      $display("timeout: the tests did not finish within %0d clock cycles", limit);
      $display("tests failed");
      $fatal(1, "watchdog expired");
   end

   initial begin : main
      resp_t           resp;
      wb_pkg::wb_dat_t rdat;
      void'($urandom(26));
      rst_n_i  = 1'b0;
      wb_adr_i = '0;
      wb_dat_i = '0;
      wb_sel_i = '0;
      wb_we_i  = 1'b0;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      build_table();
      table_ready = 1'b1;

      repeat (RESET_CYCLES) @(negedge clk);
      check_resp("after reset", RESP_NONE, sample_resp()); // Reset values of the response flops
      rst_n_i = 1'b1;
      @(negedge clk);

      for (int n = 0; n < tbl_name.size(); n++) begin
         run_access(tbl_adr[n], tbl_we[n], tbl_dat[n], tbl_sel[n], resp, rdat);
         check_resp(tbl_name[n], tbl_resp[n], resp);
         if (resp == RESP_ACK) begin
            if (tbl_we[n]) begin
               model_write(addr_to_word(tbl_adr[n]), tbl_dat[n], tbl_sel[n]);
            end else begin
               check_dat(tbl_name[n], tbl_exp[n], rdat);
            end
         end
      end

      run_random(RAND_COUNT);

      $display("all tests passed");
      $finish;
   end

endmodule

// File: tb/tile_mem_props.sv
`timescale 1ns/1ns

module tile_mem_props (
   input logic clk_i,
   input logic rst_n_i,
   input logic cyc_i,
   input logic stb_i,
   input logic ack_i,
   input logic err_i
);

   logic req;

   assign req = cyc_i & stb_i; // Request in progress

   a_resp_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(ack_i && err_i))
      else $error("ack and err are high in the same cycle");

   // Fixed one cycle latency on the top-level bus
   a_resp_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (ack_i || err_i) |-> $past(req))
      else $error("response without a request in the cycle before");

   a_ack_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ack_i |=> !ack_i)
      else $error("ack stays high for more than one cycle");

   a_err_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      err_i |=> !err_i)
      else $error("err stays high for more than one cycle");

endmodule

bind tile_mem_top tile_mem_props u_props (
   .clk_i   (clk),
   .rst_n_i (rst_n_i),
   .cyc_i   (wb_cyc_i),
   .stb_i   (wb_stb_i),
   .ack_i   (wb_ack_o),
   .err_i   (wb_err_o)
);
